//--- verilog/core_pkg.sv
package core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // {funct7[5], funct3}
  typedef logic [3:0]  alu_op_t;

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

endpackage

//--- verilog/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl #(
  parameter int ROB_DEPTH = 4,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic               in_valid,
  input  core_pkg::xlen_t    in_instr,
  output logic               in_ready,
  input  logic               rs_full,
  input  logic               rob_full,
  output logic               dispatch,
  output core_pkg::reg_idx_t rs1,
  output core_pkg::reg_idx_t rs2,
  output core_pkg::reg_idx_t rd,
  input  logic               src1_busy,
  input  logic               src2_busy,
  input  logic [TAG_W-1:0]   src1_tag,
  input  logic [TAG_W-1:0]   src2_tag,
  input  core_pkg::xlen_t    reg1_value,
  input  core_pkg::xlen_t    reg2_value,
  input  logic               rob1_done,
  input  logic               rob2_done,
  input  core_pkg::xlen_t    rob1_value,
  input  core_pkg::xlen_t    rob2_value,
  output core_pkg::alu_op_t  op,
  output core_pkg::xlen_t    opnd1,
  output core_pkg::xlen_t    opnd2,
  output logic               opnd1_ready,
  output logic               opnd2_ready,
  output logic [TAG_W-1:0]   opnd1_tag,
  output logic [TAG_W-1:0]   opnd2_tag
);
  import core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  xlen_t      imm_i;
  xlen_t      imm_u;
  logic       supported;

  assign opcode = in_instr[6:0];
  assign funct3 = in_instr[14:12];
  assign rd     = in_instr[11:7];
  assign rs1    = in_instr[19:15];
  assign rs2    = in_instr[24:20];
  assign imm_i  = {{20{in_instr[31]}}, in_instr[31:20]};
  assign imm_u  = {in_instr[31:12], 12'b0};

  assign supported = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || (opcode == OPC_LUI);

  assign in_ready = !rs_full && !rob_full;
  assign dispatch = in_valid && in_ready;

  always_comb begin
    case (opcode)
      OPC_OP:     op = {in_instr[30], funct3};
      // bit 30 is part of the immediate except for srai
      OPC_OP_IMM: op = {(funct3 == 3'b101) & in_instr[30], funct3};
      default:    op = ALU_ADD;
    endcase
  end

  // register file first, then rob, else wait on the tag
  always_comb begin
    opnd1_tag = src1_tag;
    opnd2_tag = src2_tag;
    if (opcode == OPC_LUI) begin
      opnd1       = '0;
      opnd1_ready = 1'b1;
    end else if (!src1_busy) begin
      opnd1       = reg1_value;
      opnd1_ready = 1'b1;
    end else begin
      opnd1       = rob1_done ? rob1_value : '0;
      opnd1_ready = rob1_done;
    end
    if (opcode == OPC_OP) begin
      if (!src2_busy) begin
        opnd2       = reg2_value;
        opnd2_ready = 1'b1;
      end else begin
        opnd2       = rob2_done ? rob2_value : '0;
        opnd2_ready = rob2_done;
      end
    end else begin
      opnd2       = (opcode == OPC_OP_IMM) ? imm_i : imm_u;
      opnd2_ready = 1'b1;
    end
  end

  always_comb begin
    if (dispatch) begin
      assert (supported)
        else $error("issue_ctrl: unsupported opcode %b accepted", opcode);
    end
  end

endmodule

//--- verilog/regfile_scoreboard.sv
`timescale 1ns/100ps

module regfile_scoreboard #(
  parameter int ROB_DEPTH = 4,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  output logic               src1_busy,
  output logic               src2_busy,
  output logic [TAG_W-1:0]   src1_tag,
  output logic [TAG_W-1:0]   src2_tag,
  output core_pkg::xlen_t    reg1_value,
  output core_pkg::xlen_t    reg2_value,
  input  logic               dispatch,
  input  core_pkg::reg_idx_t rd,
  input  logic [TAG_W-1:0]   dispatch_tag,
  input  logic               commit_valid,
  input  core_pkg::reg_idx_t commit_rd,
  input  core_pkg::xlen_t    commit_value,
  input  logic [TAG_W-1:0]   commit_tag
);
  import core_pkg::*;

  xlen_t            regs [32];
  logic [31:0]      busy;
  logic [TAG_W-1:0] tags [32];
  logic             commit_wr;
  logic             busy_set;
  logic             busy_clr;

  assign commit_wr = commit_valid && (commit_rd != '0);
  assign busy_set  = dispatch && (rd != '0);

  // only the last writer frees the register, and a new rename wins
  assign busy_clr = commit_wr && (tags[commit_rd] == commit_tag) &&
                    !(busy_set && (rd == commit_rd));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_wr) begin
        regs[commit_rd] <= commit_value;
      end
      if (busy_clr) begin
        busy[commit_rd] <= 1'b0;
      end
      if (busy_set) begin
        busy[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy_set) begin
      tags[rd] <= dispatch_tag;
    end
  end

  assign reg1_value = regs[rs1];
  assign reg2_value = regs[rs2];
  assign src1_busy  = busy[rs1];
  assign src2_busy  = busy[rs2];
  assign src1_tag   = tags[rs1];
  assign src2_tag   = tags[rs2];

  assert property (@(posedge clk) disable iff (!rst_n) !busy[0])
    else $error("regfile_scoreboard: x0 marked busy");

endmodule

//--- verilog/alu_station.sv
`timescale 1ns/100ps

module alu_station #(
  parameter int RS_DEPTH  = 3,
  parameter int ROB_DEPTH = 4,
  localparam int TAG_W = $clog2(ROB_DEPTH),
  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dispatch,
  input  core_pkg::alu_op_t op,
  input  core_pkg::xlen_t   opnd1,
  input  core_pkg::xlen_t   opnd2,
  input  logic              opnd1_ready,
  input  logic              opnd2_ready,
  input  logic [TAG_W-1:0]  opnd1_tag,
  input  logic [TAG_W-1:0]  opnd2_tag,
  input  logic [TAG_W-1:0]  dispatch_tag,
  output logic              rs_full,
  output logic              cdb_valid,
  output logic [TAG_W-1:0]  cdb_tag,
  output core_pkg::xlen_t   cdb_value
);
  import core_pkg::*;

  logic [RS_DEPTH-1:0] ent_valid;
  logic [RS_DEPTH-1:0] ent_rdy1;
  logic [RS_DEPTH-1:0] ent_rdy2;
  alu_op_t             ent_op   [RS_DEPTH];
  xlen_t               ent_val1 [RS_DEPTH];
  xlen_t               ent_val2 [RS_DEPTH];
  logic [TAG_W-1:0]    ent_tag1 [RS_DEPTH];
  logic [TAG_W-1:0]    ent_tag2 [RS_DEPTH];
  logic [TAG_W-1:0]    ent_dest [RS_DEPTH];
  logic [RS_DEPTH-1:0] wake1;
  logic [RS_DEPTH-1:0] wake2;
  logic                sel_vld;
  logic [IDX_W-1:0]    sel_idx;
  logic [IDX_W-1:0]    free_idx;
  logic                d1_rdy;
  logic                d2_rdy;
  xlen_t               d1_val;
  xlen_t               d2_val;
  xlen_t               alu_a;
  xlen_t               alu_b;
  xlen_t               alu_result;

  assign rs_full = &ent_valid;

  // operand arriving on the bus in the dispatch cycle
  assign d1_rdy = opnd1_ready || (cdb_valid && (cdb_tag == opnd1_tag));
  assign d2_rdy = opnd2_ready || (cdb_valid && (cdb_tag == opnd2_tag));
  assign d1_val = opnd1_ready ? opnd1 : cdb_value;
  assign d2_val = opnd2_ready ? opnd2 : cdb_value;

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      wake1[i] = cdb_valid && ent_valid[i] && !ent_rdy1[i] && (ent_tag1[i] == cdb_tag);
      wake2[i] = cdb_valid && ent_valid[i] && !ent_rdy2[i] && (ent_tag2[i] == cdb_tag);
    end
  end

  // lowest index wins
  always_comb begin
    sel_vld  = 1'b0;
    sel_idx  = '0;
    free_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i]) begin
        sel_vld = 1'b1;
        sel_idx = IDX_W'(i);
      end
      if (!ent_valid[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  assign alu_a = ent_val1[sel_idx];
  assign alu_b = ent_val2[sel_idx];

  always_comb begin
    case (ent_op[sel_idx])
      ALU_ADD:  alu_result = alu_a + alu_b;
      ALU_SUB:  alu_result = alu_a - alu_b;
      ALU_SLL:  alu_result = alu_a << alu_b[4:0];
      ALU_SLT:  alu_result = xlen_t'($signed(alu_a) < $signed(alu_b));
      ALU_SLTU: alu_result = xlen_t'(alu_a < alu_b);
      ALU_XOR:  alu_result = alu_a ^ alu_b;
      ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
      ALU_SRA:  alu_result = xlen_t'($signed(alu_a) >>> alu_b[4:0]);
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      default:  alu_result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
      ent_rdy1  <= '0;
      ent_rdy2  <= '0;
      cdb_valid <= 1'b0;
    end else begin
      ent_rdy1 <= ent_rdy1 | wake1;
      ent_rdy2 <= ent_rdy2 | wake2;
      if (sel_vld) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (dispatch) begin
        ent_valid[free_idx] <= 1'b1;
        ent_rdy1[free_idx]  <= d1_rdy;
        ent_rdy2[free_idx]  <= d2_rdy;
      end
      cdb_valid <= sel_vld;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (wake1[i]) begin
        ent_val1[i] <= cdb_value;
      end
      if (wake2[i]) begin
        ent_val2[i] <= cdb_value;
      end
    end
    if (dispatch) begin
      ent_op[free_idx]   <= op;
      ent_val1[free_idx] <= d1_val;
      ent_val2[free_idx] <= d2_val;
      ent_tag1[free_idx] <= opnd1_tag;
      ent_tag2[free_idx] <= opnd2_tag;
      ent_dest[free_idx] <= dispatch_tag;
    end
    if (sel_vld) begin
      cdb_tag   <= ent_dest[sel_idx];
      cdb_value <= alu_result;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) dispatch |-> !rs_full)
    else $error("alu_station: dispatch into a full station");

endmodule

//--- verilog/rob.sv
`timescale 1ns/100ps

module rob #(
  parameter int ROB_DEPTH = 4,
  localparam int TAG_W = $clog2(ROB_DEPTH),
  localparam int CNT_W = $clog2(ROB_DEPTH + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               dispatch,
  input  core_pkg::reg_idx_t rd,
  output logic [TAG_W-1:0]   dispatch_tag,
  output logic               rob_full,
  input  logic [TAG_W-1:0]   src1_tag,
  input  logic [TAG_W-1:0]   src2_tag,
  output logic               rob1_done,
  output logic               rob2_done,
  output core_pkg::xlen_t    rob1_value,
  output core_pkg::xlen_t    rob2_value,
  input  logic               cdb_valid,
  input  logic [TAG_W-1:0]   cdb_tag,
  input  core_pkg::xlen_t    cdb_value,
  output logic               commit_valid,
  output core_pkg::reg_idx_t commit_rd,
  output core_pkg::xlen_t    commit_value,
  output logic [TAG_W-1:0]   commit_tag
);
  import core_pkg::*;

  logic [ROB_DEPTH-1:0] ent_valid;
  logic [ROB_DEPTH-1:0] ent_done;
  reg_idx_t             ent_rd    [ROB_DEPTH];
  xlen_t                ent_value [ROB_DEPTH];
  logic [TAG_W-1:0]     head;
  logic [TAG_W-1:0]     tail;
  logic [CNT_W-1:0]     count;
  logic [CNT_W-1:0]     count_next;
  logic                 full_q;

  function automatic logic [TAG_W-1:0] ptr_inc(input logic [TAG_W-1:0] p);
    return (p == TAG_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign dispatch_tag = tail;
  assign rob_full     = full_q;
  assign count_next   = count + CNT_W'(dispatch) - CNT_W'(commit_valid);

  // operand forwarding from finished but not yet retired entries
  assign rob1_done  = ent_done[src1_tag];
  assign rob2_done  = ent_done[src2_tag];
  assign rob1_value = ent_value[src1_tag];
  assign rob2_value = ent_value[src2_tag];

  assign commit_valid = ent_valid[head] && ent_done[head];
  assign commit_rd    = ent_rd[head];
  assign commit_value = ent_value[head];
  assign commit_tag   = head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      // looks full until out of reset
      full_q    <= 1'b1;
    end else begin
      if (cdb_valid) begin
        ent_done[cdb_tag] <= 1'b1;
      end
      if (commit_valid) begin
        ent_valid[head] <= 1'b0;
        head            <= ptr_inc(head);
      end
      if (dispatch) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= ptr_inc(tail);
      end
      count  <= count_next;
      full_q <= (count_next == CNT_W'(ROB_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (cdb_valid) begin
      ent_value[cdb_tag] <= cdb_value;
    end
    if (dispatch) begin
      ent_rd[tail] <= rd;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
                   cdb_valid |-> ent_valid[cdb_tag] && !ent_done[cdb_tag])
    else $error("rob: broadcast to tag %0d that is free or already done", cdb_tag);

endmodule

//--- verilog/ooo_core.sv
`timescale 1ns/100ps

module ooo_core #(
  parameter int ROB_DEPTH = 4,
  parameter int RS_DEPTH  = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  core_pkg::xlen_t    in_instr,
  output logic               in_ready,
  output logic               commit_valid,
  output core_pkg::reg_idx_t commit_rd,
  output core_pkg::xlen_t    commit_value
);
  import core_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  // dispatch and operand lookup
  logic             rs_full;
  logic             rob_full;
  logic             dispatch;
  reg_idx_t         rs1;
  reg_idx_t         rs2;
  reg_idx_t         rd;
  logic             src1_busy;
  logic             src2_busy;
  logic [TAG_W-1:0] src1_tag;
  logic [TAG_W-1:0] src2_tag;
  xlen_t            reg1_value;
  xlen_t            reg2_value;
  logic             rob1_done;
  logic             rob2_done;
  xlen_t            rob1_value;
  xlen_t            rob2_value;
  alu_op_t          op;
  xlen_t            opnd1;
  xlen_t            opnd2;
  logic             opnd1_ready;
  logic             opnd2_ready;
  logic [TAG_W-1:0] opnd1_tag;
  logic [TAG_W-1:0] opnd2_tag;
  logic [TAG_W-1:0] dispatch_tag;

  // result bus and retire
  logic             cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  xlen_t            cdb_value;
  logic [TAG_W-1:0] commit_tag;

  issue_ctrl #(.ROB_DEPTH(ROB_DEPTH)) issue_ctrl (.*);

  regfile_scoreboard #(.ROB_DEPTH(ROB_DEPTH)) regfile_scoreboard (.*);

  alu_station #(
    .RS_DEPTH (RS_DEPTH),
    .ROB_DEPTH(ROB_DEPTH)
  ) alu_station (.*);

  rob #(.ROB_DEPTH(ROB_DEPTH)) rob (.*);

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk = ~clk;
    end
  end

  // release just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- tests/tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;
  import core_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DLY    = 1;
  localparam int ROB_DEPTH    = 4;
  localparam int RS_DEPTH     = 3;
  localparam int TAB_LEN      = 27;
  localparam int BURST_LEN    = 8;
  localparam int DRAIN_CYCLES = 8;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  xlen_t    in_instr;
  logic     in_ready;
  logic     commit_valid;
  reg_idx_t commit_rd;
  xlen_t    commit_value;

  string    name_tab  [TAB_LEN];
  xlen_t    instr_tab [TAB_LEN];
  reg_idx_t rd_tab    [TAB_LEN];
  xlen_t    val_tab   [TAB_LEN];

  int          n_rows        = 0;
  int          n_accepted    = 0;
  int          n_commits     = 0;
  int          n_errors      = 0;
  logic        burst_stalled = 1'b0;
  int unsigned lcg_state     = 96;

  tb_clock_gen #(
    .PERIOD      (CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) u_clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  ooo_core #(
    .ROB_DEPTH(ROB_DEPTH),
    .RS_DEPTH (RS_DEPTH)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .in_ready    (in_ready),
    .commit_valid(commit_valid),
    .commit_rd   (commit_rd),
    .commit_value(commit_value)
  );

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // rv32i encodings
  function automatic xlen_t r_type(input logic [6:0] funct7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] funct3,
                                   input reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic xlen_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] funct3, input reg_idx_t rd);
    return {imm, rs1, funct3, rd, 7'b0010011};
  endfunction

  function automatic xlen_t u_type(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(input string name, input xlen_t instr, input reg_idx_t rd,
                         input xlen_t value);
    name_tab[n_rows]  = name;
    instr_tab[n_rows] = instr;
    rd_tab[n_rows]    = rd;
    val_tab[n_rows]   = value;
    n_rows++;
  endtask

  task automatic check_equal(input string what, input xlen_t got, input xlen_t expected);
    if (got !== expected) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
      n_errors++;
    end
  endtask

  // first BURST_LEN rows go in back to back and must overrun the rob
  task automatic fill_table();
    add_row("addi x1", i_type(12'd100, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0064);
    add_row("addi x2", i_type(12'hFF9, 5'd0, 3'b000, 5'd2), 5'd2, 32'hFFFF_FFF9);
    add_row("add x3", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h0000_005D);
    add_row("sub x4", r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_006B);
    add_row("lui x5", u_type(20'h12345, 5'd5), 5'd5, 32'h1234_5000);
    add_row("xor x6", r_type(7'h00, 5'd1, 5'd5, 3'b100, 5'd6), 5'd6, 32'h1234_5064);
    add_row("xori x7", i_type(12'h0F0, 5'd2, 3'b100, 5'd7), 5'd7, 32'hFFFF_FF09);
    add_row("or x8", r_type(7'h00, 5'd5, 5'd3, 3'b110, 5'd8), 5'd8, 32'h1234_505D);
    add_row("ori x9", i_type(12'h5A5, 5'd0, 3'b110, 5'd9), 5'd9, 32'h0000_05A5);
    add_row("and x10", r_type(7'h00, 5'd9, 5'd6, 3'b111, 5'd10), 5'd10, 32'h0000_0024);
    add_row("andi x11", i_type(12'h7F0, 5'd2, 3'b111, 5'd11), 5'd11, 32'h0000_07F0);
    add_row("sll x12", r_type(7'h00, 5'd9, 5'd1, 3'b001, 5'd12), 5'd12, 32'h0000_0C80);
    add_row("slli x13", i_type(12'h004, 5'd2, 3'b001, 5'd13), 5'd13, 32'hFFFF_FF90);
    add_row("srl x14", r_type(7'h00, 5'd9, 5'd2, 3'b101, 5'd14), 5'd14, 32'h07FF_FFFF);
    add_row("srai x15", i_type(12'h402, 5'd2, 3'b101, 5'd15), 5'd15, 32'hFFFF_FFFE);
    add_row("srli x16", i_type(12'h00C, 5'd5, 3'b101, 5'd16), 5'd16, 32'h0001_2345);
    add_row("sra x17", r_type(7'h20, 5'd9, 5'd13, 3'b101, 5'd17), 5'd17, 32'hFFFF_FFFC);
    add_row("slt x18", r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd18), 5'd18, 32'h0000_0001);
    add_row("sltu x19", r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd19), 5'd19, 32'h0000_0000);
    add_row("slti x20", i_type(12'hFFA, 5'd2, 3'b010, 5'd20), 5'd20, 32'h0000_0001);
    add_row("sltiu x21", i_type(12'hFFF, 5'd1, 3'b011, 5'd21), 5'd21, 32'h0000_0001);
    // x0 keeps zero though the commit reports the sum
    add_row("addi x0", i_type(12'd5, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_0069);
    add_row("addi x25", i_type(12'd1, 5'd3, 3'b000, 5'd25), 5'd25, 32'h0000_005E);
    add_row("addi x25", i_type(12'd1, 5'd25, 3'b000, 5'd25), 5'd25, 32'h0000_005F);
    add_row("add x26", r_type(7'h00, 5'd25, 5'd25, 3'b000, 5'd26), 5'd26, 32'h0000_00BE);
    // one rob depth after the x0 write, so that write has retired
    add_row("add x22", r_type(7'h00, 5'd23, 5'd0, 3'b000, 5'd22), 5'd22, 32'h0000_0000);
    add_row("sub x27", r_type(7'h20, 5'd12, 5'd26, 3'b000, 5'd27), 5'd27, 32'hFFFF_F43E);
  endtask

  initial begin : stimulus
    int   gap;
    logic accepted;
    in_valid = 1'b0;
    in_instr = '0;
    fill_table();
    wait (rst_n === 1'b1);
    @(posedge clk);
    #DRIVE_DLY;
    for (int i = 0; i < TAB_LEN; i++) begin
      gap = (i < BURST_LEN) ? 0 : int'((lcg_next() >> 16) % 4);
      if (gap > 0) begin
        in_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #DRIVE_DLY;
        end
      end
      in_valid = 1'b1;
      in_instr = instr_tab[i];
      accepted = 1'b0;
      // in_ready only changes after a rising edge
      while (!accepted) begin
        @(negedge clk);
        accepted = in_ready;
        if (!accepted && i >= ROB_DEPTH && i < BURST_LEN) begin
          burst_stalled = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DLY;
      end
      n_accepted++;
    end
    in_valid = 1'b0;
    in_instr = '0;
    wait (n_commits >= TAB_LEN);
    // room for any duplicate commit to show up
    repeat (DRAIN_CYCLES) @(posedge clk);
    check_equal("commit count", 32'(n_commits), 32'(n_accepted));
    if (!burst_stalled) begin
      $display("in_ready never went low during the back-to-back burst");
      n_errors++;
    end
    $display("%0d tests, %0d accepted, %0d committed, %0d errors",
             TAB_LEN, n_accepted, n_commits, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : commit_monitor
    int errs_before;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (commit_valid === 1'b1) begin
        if (n_accepted == 0) begin
          $display("a commit appeared before any instruction was accepted");
          n_errors++;
        end
        if (n_commits >= TAB_LEN) begin
          $display("an extra commit appeared after the whole table had retired");
          n_errors++;
        end else begin
          errs_before = n_errors;
          check_equal({name_tab[n_commits], " rd"}, 32'(commit_rd), 32'(rd_tab[n_commits]));
          check_equal({name_tab[n_commits], " value"}, commit_value, val_tab[n_commits]);
          $display("test %0d %s: %s", n_commits, name_tab[n_commits],
                   (n_errors == errs_before) ? "ok" : "mismatch");
        end
        n_commits++;
      end else if (commit_valid !== 1'b0) begin
        $display("commit_valid is unknown after reset");
        n_errors++;
      end
    end
  end

  initial begin : watchdog
    #((RESET_CYCLES + TAB_LEN * 20) * CLK_PERIOD);
    $display("timeout: only %0d of %0d instructions retired in time", n_commits, TAB_LEN);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
verilog/core_pkg.sv
verilog/issue_ctrl.sv
verilog/regfile_scoreboard.sv
verilog/alu_station.sv
verilog/rob.sv
verilog/ooo_core.sv
tests/tb_clock_gen.sv
tests/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ooo_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ooo_core -f verilog.f -o sim_ooo_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_ooo_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
  exit 0
fi
exit 1
